// ==== rtl/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	////////////////////////////////////////////////////////////
	// Download port and cheat code widths

	localparam int DATA_W  = 16;
	localparam int ADDR_W  = 25;   // Byte address
	localparam int INDEX_W = 8;
	localparam int CODE_W  = 128;
	localparam int QUIRK_W = 8;

	localparam logic [INDEX_W-1:0] CHEAT_INDEX = '1;

	////////////////////////////////////////////////////////////
	// Cartridge header locations

	localparam logic [ADDR_W-1:0] HDR_REGION_ADDR   = 25'h1F0;
	localparam logic [ADDR_W-1:0] HDR_REGION_ADDR2  = 25'h1F2;
	localparam logic [ADDR_W-1:0] HDR_DONE_ADDR     = 25'h200;
	localparam logic [ADDR_W-1:0] SERIAL_ADDR_FIRST = 25'h182;
	localparam logic [ADDR_W-1:0] SERIAL_ADDR_LAST  = 25'h18A;
	localparam logic [ADDR_W-1:0] QUIRK_DECIDE_ADDR = 25'h18C;

	// Region codes, as the core expects them
	localparam logic [1:0] REGION_JP = 2'd0;
	localparam logic [1:0] REGION_US = 2'd1;
	localparam logic [1:0] REGION_EU = 2'd2;

	localparam logic [1:0] PRIO_US_EU_JP = 2'd0;
	localparam logic [1:0] PRIO_EU_US_JP = 2'd1;
	localparam logic [1:0] PRIO_US_JP_EU = 2'd2;
	localparam logic [1:0] PRIO_JP_US_EU = 2'd3;

	////////////////////////////////////////////////////////////
	// Emulation quirks, keyed by the header serial

	localparam int Q_SRAM   = 0;
	localparam int Q_EEPROM = 1;
	localparam int Q_FIFO   = 2;
	localparam int Q_NORAM  = 3;
	localparam int Q_PIER   = 4;
	localparam int Q_SVP    = 5;
	localparam int Q_FMBUSY = 6;
	localparam int Q_SCHAN  = 7;

	localparam int QUIRK_TABLE_LEN = 24;

	// First match wins, so order matters
	localparam logic [63:0] QUIRK_SERIALS [QUIRK_TABLE_LEN] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ",
		"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
		"00004076", "T-12046 ", "T-12053 ", "G-4524  ", "T-113016",
		"T-89016 ", "T-574023", "T-574013", "MK-1229 ", "G-7001  ",
		"T-35036 ", "T-25073 ", "MK-1137-", "T-68???-"
	};

	localparam int QUIRK_BITS [QUIRK_TABLE_LEN] = '{
		Q_SRAM, Q_SRAM, Q_SRAM, Q_SRAM, Q_SRAM,
		Q_EEPROM, Q_EEPROM, Q_EEPROM, Q_EEPROM, Q_EEPROM,
		Q_EEPROM, Q_EEPROM, Q_EEPROM, Q_EEPROM, Q_NORAM,
		Q_FIFO, Q_PIER, Q_PIER, Q_SVP, Q_SVP,
		Q_FMBUSY, Q_FMBUSY, Q_FMBUSY, Q_SCHAN
	};

endpackage

`default_nettype wire

// ==== rtl/rom_write_pacer.sv ====
`timescale 1ns/10ps
`default_nettype none

module rom_write_pacer #(
	parameter bit ACK_CHECK = 1'b1
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          cart_load,
	input  wire                          ioctl_wr,
	input  wire  [cart_pkg::ADDR_W-1:0]  ioctl_addr,
	input  wire  [cart_pkg::DATA_W-1:0]  ioctl_data,
	output logic                         ioctl_wait,
	output logic                         rom_wr,
	input  wire                          rom_wrack,
	output logic [cart_pkg::ADDR_W-1:0]  rom_waddr,
	output logic [cart_pkg::DATA_W-1:0]  rom_wdata,
	output logic [cart_pkg::ADDR_W-1:0]  rom_size
);

	logic old_load;

	////////////////////////////////////////////////////////////
	// Toggle request, host stall

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr     <= rom_wrack;   // Nothing outstanding
		end else begin
			old_load <= cart_load;
			if (old_load & ~cart_load)
				ioctl_wait <= 1'b0;

			if (~old_load & cart_load) begin
				rom_wr <= rom_wrack;   // Resync with memory side
			end else if (cart_load) begin
				if (ioctl_wr) begin
					ioctl_wait <= 1'b1;
					rom_wr     <= ~rom_wr;
				end else if (ioctl_wait && (rom_wr == rom_wrack)) begin
					ioctl_wait <= 1'b0;   // Word stored
				end
			end
		end
	end

	// Word held for memory until acknowledged, byte swapped
	always_ff @(posedge clk_sys) begin
		if (cart_load & ioctl_wr) begin
			rom_waddr <= ioctl_addr;
			rom_wdata <= {ioctl_data[7:0], ioctl_data[15:8]};
		end
		if (old_load & ~cart_load)
			rom_size <= ioctl_addr;   // Last address of the image
	end

	if (ACK_CHECK) begin : g_check
		// Host must honour the stall, else a word is lost
		a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
			!(ioctl_wr && ioctl_wait));
	end

endmodule

`default_nettype wire

// ==== rtl/cart_header_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module cart_header_scan #(
	parameter bit ACK_CHECK = 1'b1
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          cart_load,
	input  wire                          ioctl_wr,
	input  wire  [cart_pkg::ADDR_W-1:0]  ioctl_addr,
	input  wire  [cart_pkg::DATA_W-1:0]  ioctl_data,
	output logic                         hdr_j,
	output logic                         hdr_u,
	output logic                         hdr_e,
	output logic                         hdr_ready,
	output logic [cart_pkg::QUIRK_W-1:0] quirks
);

	import cart_pkg::*;

	logic                old_load;
	logic [2:0]          letters;   // {j, u, e}
	logic [63:0]         cart_id;
	logic [QUIRK_W-1:0]  quirk_hit;
	wire                 hdr_wr    = ioctl_wr & cart_load;
	wire                 load_rise = ~old_load & cart_load;

	function automatic logic [2:0] letter_flags(input logic [7:0] ch);
		if (ch == "J")
			return 3'b100;
		else if (ch == "U")
			return 3'b010;
		else if (ch >= "0" && ch <= "Z")
			return 3'b001;   // Anything else counts as Europe
		return 3'b000;
	endfunction

	////////////////////////////////////////////////////////////
	// Region letters

	always_comb begin
		letters = 3'b000;
		if (ioctl_addr == HDR_REGION_ADDR)
			letters = letter_flags(ioctl_data[7:0]) | letter_flags(ioctl_data[15:8]);
		else if (ioctl_addr == HDR_REGION_ADDR2)
			letters = letter_flags(ioctl_data[7:0]);   // Only the first byte here
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load  <= 1'b0;
			hdr_ready <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
		end else begin
			old_load <= cart_load;
			if (load_rise)
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
			else if (hdr_wr)
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | letters;

			if (old_load & ~cart_load)
				hdr_ready <= 1'b0;
			else if (hdr_wr && ioctl_addr == HDR_DONE_ADDR)
				hdr_ready <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Serial number and quirk lookup

	// Serial starts on the odd byte 0x183
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (ioctl_addr)
				SERIAL_ADDR_FIRST:         cart_id[63:56] <= ioctl_data[15:8];
				SERIAL_ADDR_FIRST + 25'd2: cart_id[55:40] <= {ioctl_data[7:0], ioctl_data[15:8]};
				SERIAL_ADDR_FIRST + 25'd4: cart_id[39:24] <= {ioctl_data[7:0], ioctl_data[15:8]};
				SERIAL_ADDR_FIRST + 25'd6: cart_id[23:8]  <= {ioctl_data[7:0], ioctl_data[15:8]};
				SERIAL_ADDR_LAST:          cart_id[7:0]   <= ioctl_data[7:0];
				default: ;
			endcase
		end
	end

	// Walk the table backwards so the lowest entry wins
	always_comb begin
		quirk_hit = '0;
		for (int i = QUIRK_TABLE_LEN - 1; i >= 0; i--) begin
			if (cart_id == QUIRK_SERIALS[i])
				quirk_hit = QUIRK_W'(1) << QUIRK_BITS[i];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			quirks <= '0;
		else if (load_rise)
			quirks <= '0;
		else if (hdr_wr && ioctl_addr == QUIRK_DECIDE_ADDR)
			quirks <= quirks | quirk_hit;
	end

	if (ACK_CHECK) begin : g_check
		// One quirk per cart over the whole download
		a_quirk_onehot: assert property (@(posedge clk_sys) disable iff (reset)
			$onehot0(quirks));
	end

endmodule

`default_nettype wire

// ==== rtl/region_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module region_select (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          hdr_ready,
	input  wire                          hdr_j,
	input  wire                          hdr_u,
	input  wire                          hdr_e,
	input  wire                          auto_enable,
	input  wire                          use_header,
	input  wire  [1:0]                   region_priority,
	input  wire  [cart_pkg::INDEX_W-1:0] ioctl_index,
	output logic [1:0]                   region_req,
	output logic                         region_set
);

	import cart_pkg::*;

	logic       old_ready;
	logic [5:0] order;   // First choice in the top pair
	logic [1:0] pick;
	wire  [3:0] flags = {1'b0, hdr_e, hdr_u, hdr_j};   // Indexed by region code

	always_comb begin
		case (region_priority)
			PRIO_US_EU_JP: order = {REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: order = {REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: order = {REGION_US, REGION_JP, REGION_EU};
			PRIO_JP_US_EU: order = {REGION_JP, REGION_US, REGION_EU};
		endcase
	end

	always_comb begin
		if (flags[order[5:4]])
			pick = order[5:4];
		else if (flags[order[3:2]])
			pick = order[3:2];
		else if (flags[order[1:0]])
			pick = order[1:0];
		else
			pick = order[5:4];   // No letter found
	end

	////////////////////////////////////////////////////////////
	// Region request on header ready

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_ready  <= 1'b0;
			region_set <= 1'b0;
			region_req <= REGION_JP;
		end else begin
			old_ready <= hdr_ready;
			if (auto_enable & hdr_ready & ~old_ready) begin
				if (use_header) begin
					region_set <= 1'b1;
					region_req <= pick;
				end else begin
					// Region taken from the file extension slot
					region_set <= |ioctl_index;
					region_req <= ioctl_index[INDEX_W-1 -: 2];
				end
			end
			if (old_ready & ~hdr_ready)
				region_set <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cheat_code_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module cheat_code_loader (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          code_load,
	input  wire                          ioctl_wr,
	input  wire  [cart_pkg::ADDR_W-1:0]  ioctl_addr,
	input  wire  [cart_pkg::DATA_W-1:0]  ioctl_data,
	output logic [cart_pkg::CODE_W-1:0]  code,
	output logic                         code_valid,
	output logic                         code_clear
);

	import cart_pkg::*;

	wire       code_wr = code_load & ioctl_wr;
	// Field f = addr[3:2] sits at (3 - f) * 32, addr[1] picks the upper word
	wire [6:0] base    = {~ioctl_addr[3:2], ioctl_addr[1], 4'b0000};

	////////////////////////////////////////////////////////////
	// Code assembly, {flags, address, compare, replace}

	always_ff @(posedge clk_sys) begin
		if (code_wr & ~ioctl_addr[0])
			code[base +: DATA_W] <= ioctl_data;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			code_valid <= code_wr && ioctl_addr[3:0] == 4'd14;   // Last word
			code_clear <= code_wr && ioctl_addr == '0;          // New cheat file
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cart_loader_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cart_loader_top #(
	parameter bit ACK_CHECK = 1'b1
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          ioctl_download,
	input  wire  [cart_pkg::INDEX_W-1:0] ioctl_index,
	input  wire                          ioctl_wr,
	input  wire  [cart_pkg::ADDR_W-1:0]  ioctl_addr,
	input  wire  [cart_pkg::DATA_W-1:0]  ioctl_data,
	output logic                         ioctl_wait,
	input  wire                          auto_enable,
	input  wire                          use_header,
	input  wire  [1:0]                   region_priority,
	output logic                         rom_wr,
	input  wire                          rom_wrack,
	output logic [cart_pkg::ADDR_W-1:0]  rom_waddr,
	output logic [cart_pkg::DATA_W-1:0]  rom_wdata,
	output logic [cart_pkg::ADDR_W-1:0]  rom_size,
	output logic [cart_pkg::QUIRK_W-1:0] quirks,
	output logic [1:0]                   region_req,
	output logic                         region_set,
	output logic [cart_pkg::CODE_W-1:0]  code,
	output logic                         code_valid,
	output logic                         code_clear
);

	import cart_pkg::*;

	////////////////////////////////////////////////////////////
	// Download type

	wire code_index = (ioctl_index == CHEAT_INDEX);
	wire cart_load  = ioctl_download & ~code_index;
	wire code_load  = ioctl_download & code_index;

	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	rom_write_pacer #(.ACK_CHECK(ACK_CHECK)) i_rom_write_pacer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_load  (cart_load),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_data (ioctl_data),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.rom_wrack  (rom_wrack),
		.rom_waddr  (rom_waddr),
		.rom_wdata  (rom_wdata),
		.rom_size   (rom_size)
	);

	cart_header_scan #(.ACK_CHECK(ACK_CHECK)) i_cart_header_scan (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_load  (cart_load),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_data (ioctl_data),
		.hdr_j      (hdr_j),
		.hdr_u      (hdr_u),
		.hdr_e      (hdr_e),
		.hdr_ready  (hdr_ready),
		.quirks     (quirks)
	);

	region_select i_region_select (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.hdr_ready       (hdr_ready),
		.hdr_j           (hdr_j),
		.hdr_u           (hdr_u),
		.hdr_e           (hdr_e),
		.auto_enable     (auto_enable),
		.use_header      (use_header),
		.region_priority (region_priority),
		.ioctl_index     (ioctl_index),
		.region_req      (region_req),
		.region_set      (region_set)
	);

	cheat_code_loader i_cheat_code_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.code_load  (code_load),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_data (ioctl_data),
		.code       (code),
		.code_valid (code_valid),
		.code_clear (code_clear)
	);

endmodule

`default_nettype wire

// ==== bench/cart_loader_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cart_loader_tb;

	import cart_pkg::*;

	// Whole run stays under 1500 cycles even with the slowest memory acks
	localparam int TIMEOUT_CYCLES = 20000;

	logic                clk_sys;
	logic                reset;
	logic                ioctl_download;
	logic [INDEX_W-1:0]  ioctl_index;
	logic                ioctl_wr;
	logic [ADDR_W-1:0]   ioctl_addr;
	logic [DATA_W-1:0]   ioctl_data;
	logic                ioctl_wait;
	logic                auto_enable;
	logic                use_header;
	logic [1:0]          region_priority;
	logic                rom_wr;
	logic                rom_wrack;
	logic [ADDR_W-1:0]   rom_waddr;
	logic [DATA_W-1:0]   rom_wdata;
	logic [ADDR_W-1:0]   rom_size;
	logic [QUIRK_W-1:0]  quirks;
	logic [1:0]          region_req;
	logic                region_set;
	logic [CODE_W-1:0]   code;
	logic                code_valid;
	logic                code_clear;

	int seed = 32'hbdb9_eb3c;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int rom_reqs = 0;   // Toggles seen by the memory model
	logic [ADDR_W-1:0] log_addr [$];
	logic [DATA_W-1:0] log_data [$];

	cart_loader_top #(.ACK_CHECK(1'b1)) i_cart_loader_top (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ioctl_download  (ioctl_download),
		.ioctl_index     (ioctl_index),
		.ioctl_wr        (ioctl_wr),
		.ioctl_addr      (ioctl_addr),
		.ioctl_data      (ioctl_data),
		.ioctl_wait      (ioctl_wait),
		.auto_enable     (auto_enable),
		.use_header      (use_header),
		.region_priority (region_priority),
		.rom_wr          (rom_wr),
		.rom_wrack       (rom_wrack),
		.rom_waddr       (rom_waddr),
		.rom_wdata       (rom_wdata),
		.rom_size        (rom_size),
		.quirks          (quirks),
		.region_req      (region_req),
		.region_set      (region_set),
		.code            (code),
		.code_valid      (code_valid),
		.code_clear      (code_clear)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("ERROR: run stopped after %0d cycles, a test never finished", cycles);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Memory model acknowledges each toggle after 1 to 4 cycles

	initial begin
		int delay;
		rom_wrack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (rom_wr !== rom_wrack) begin
				rom_reqs++;
				log_addr.push_back(rom_waddr);
				log_data.push_back(rom_wdata);
				delay = 1 + ($random(seed) & 3);
				repeat (delay) @(posedge clk_sys);
				#1;
				rom_wrack = rom_wr;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
			input logic [ADDR_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected 0x%h, actual 0x%h", name, exp, act);
		end
	endtask

	task automatic check_region(input string name, input logic [1:0] exp, input logic [1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_quirks(input string name, input logic [QUIRK_W-1:0] exp,
			input logic [QUIRK_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected 0b%b, actual 0b%b", name, exp, act);
		end
	endtask

	task automatic check_code(input string name, input logic [CODE_W-1:0] exp,
			input logic [CODE_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected 0x%h, actual 0x%h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Pulses are registered one edge after the write, so level is sampled now
	task automatic expect_pulse(input string what, input logic level);
		checks++;
		if (level !== 1'b1) begin
			errors++;
			$display("ERROR: %s did not pulse when expected", what);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Download port driving

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic send_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		while (ioctl_wait) begin
			@(posedge clk_sys);
			#1;
		end
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
	endtask

	task automatic start_download(input logic [INDEX_W-1:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		wait_cycles(2);   // Let the units see the start
	endtask

	task automatic end_download();
		while (ioctl_wait) begin
			@(posedge clk_sys);
			#1;
		end
		ioctl_download = 1'b0;
		wait_cycles(4);
	endtask

	task automatic wait_region_set(input string name);
		int n;
		n = 0;
		while (region_set !== 1'b1 && n < 8) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		checks++;
		if (region_set !== 1'b1) begin
			errors++;
			$display("ERROR: %s, region_set never rose after the header was done", name);
		end
	endtask

	// Serial sits in file bytes 0x183 to 0x18A between two spaces
	task automatic send_serial(input logic [63:0] serial);
		logic [7:0] file_bytes [10];
		file_bytes[0] = 8'h20;
		file_bytes[9] = 8'h20;
		for (int k = 0; k < 8; k++)
			file_bytes[k + 1] = serial[63 - 8 * k -: 8];
		for (int w = 0; w < 5; w++)
			send_word(SERIAL_ADDR_FIRST + ADDR_W'(2 * w),
				{file_bytes[2 * w + 1], file_bytes[2 * w]});
	endtask

	function automatic logic [1:0] expected_region(input logic [1:0] prio, input logic j,
			input logic u, input logic e);
		logic [1:0] order [3];
		logic       found [3];
		case (prio)
			PRIO_US_EU_JP: order = '{REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: order = '{REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: order = '{REGION_US, REGION_JP, REGION_EU};
			PRIO_JP_US_EU: order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		for (int k = 0; k < 3; k++)
			found[k] = (order[k] == REGION_JP) ? j : (order[k] == REGION_US) ? u : e;
		for (int k = 0; k < 3; k++) begin
			if (found[k])
				return order[k];
		end
		return order[0];   // No letter gives the first choice
	endfunction

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_after_reset();
		check_bit("after reset ioctl_wait", 1'b0, ioctl_wait);
		check_bit("after reset region_set", 1'b0, region_set);
		check_bit("after reset code_valid", 1'b0, code_valid);
		check_bit("after reset code_clear", 1'b0, code_clear);
		check_quirks("after reset quirks", '0, quirks);
	endtask

	task automatic test_rom_stream();
		logic [DATA_W-1:0] sent [64];
		log_addr.delete();
		log_data.delete();
		start_download(8'h00);
		for (int i = 0; i < 64; i++) begin
			sent[i] = {8'(i) ^ 8'ha5, 8'(i * 3 + 1)};
			send_word(ADDR_W'(2 * i), sent[i]);
			checks++;
			if (ioctl_wait !== 1'b1) begin
				errors++;
				$display("ERROR: ioctl_wait did not stall the host after ROM word %0d", i);
			end
		end
		end_download();
		check_count("rom stream toggles", 64, log_addr.size());
		for (int i = 0; i < 64 && i < log_addr.size(); i++) begin
			check_addr($sformatf("rom stream addr %0d", i), ADDR_W'(2 * i), log_addr[i]);
			check_word($sformatf("rom stream data %0d", i), {sent[i][7:0], sent[i][15:8]},
				log_data[i]);
		end
		check_addr("rom stream size", ADDR_W'(126), rom_size);
	endtask

	task automatic test_header_region();
		// U, E, J and no letter, then E and J with a U in the ignored byte
		logic [DATA_W-1:0] w1 [5] = '{{8'h20, "U"}, {8'h20, "E"}, {8'h20, "J"}, 16'h2020,
			{"E", 8'h20}};
		logic [DATA_W-1:0] w2 [5] = '{16'h2020, 16'h2020, 16'h2020, 16'h2020, {"U", "J"}};
		logic [2:0]        jue [5] = '{3'b010, 3'b001, 3'b100, 3'b000, 3'b101};
		logic [1:0]        want;
		string             name;
		use_header = 1'b1;
		for (int p = 0; p < 4; p++) begin
			region_priority = 2'(p);
			for (int c = 0; c < 5; c++) begin
				name = $sformatf("header prio %0d case %0d", p, c);
				want = expected_region(2'(p), jue[c][2], jue[c][1], jue[c][0]);
				start_download(8'h00);
				send_word(HDR_REGION_ADDR, w1[c]);
				send_word(HDR_REGION_ADDR2, w2[c]);
				send_word(HDR_DONE_ADDR, 16'h0000);
				wait_region_set(name);
				check_region(name, want, region_req);
				end_download();
				check_bit({name, " region_set cleared"}, 1'b0, region_set);
			end
		end
	endtask

	task automatic test_file_index_region();
		use_header = 1'b0;
		start_download(8'h80);
		send_word(HDR_DONE_ADDR, 16'h0000);
		wait_region_set("file index 0x80");
		check_region("file index 0x80", REGION_EU, region_req);
		end_download();

		start_download(8'h00);
		send_word(HDR_DONE_ADDR, 16'h0000);
		wait_cycles(4);
		check_bit("file index zero region_set", 1'b0, region_set);
		end_download();
		use_header = 1'b1;
	endtask

	task automatic test_quirks();
		int picks [8] = '{0, 5, 14, 15, 16, 18, 20, 23};
		for (int i = 0; i < 8; i++) begin
			start_download(8'h00);
			send_serial(QUIRK_SERIALS[picks[i]]);
			send_word(QUIRK_DECIDE_ADDR, 16'h2020);
			check_quirks($sformatf("quirks entry %0d", picks[i]),
				QUIRK_W'(1) << QUIRK_BITS[picks[i]], quirks);
			end_download();
		end
		start_download(8'h00);
		send_serial("XYZ-0000");
		send_word(QUIRK_DECIDE_ADDR, 16'h2020);
		check_quirks("quirks unknown serial", '0, quirks);
		end_download();
	endtask

	task automatic test_cheat_code();
		logic [DATA_W-1:0] w [8] = '{16'h0102, 16'h0304, 16'h1357, 16'h2468,
			16'hbeef, 16'hcafe, 16'h0f0f, 16'hf00d};
		int reqs_before;
		reqs_before = rom_reqs;
		start_download(CHEAT_INDEX);
		for (int i = 0; i < 8; i++) begin
			send_word(ADDR_W'(2 * i), w[i]);
			if (i == 0)
				expect_pulse("code_clear after the address 0 write", code_clear);
			else
				check_bit($sformatf("cheat code_clear word %0d", i), 1'b0, code_clear);
		end
		expect_pulse("code_valid after offset 14", code_valid);
		// Flags on top and each field low word first
		check_code("cheat code", {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]}, code);
		wait_cycles(1);
		check_bit("cheat code_valid one cycle wide", 1'b0, code_valid);
		end_download();
		check_count("cheat rom writes", reqs_before, rom_reqs);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		reset           = 1'b1;
		ioctl_download  = 1'b0;
		ioctl_index     = '0;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		auto_enable     = 1'b1;
		use_header      = 1'b1;
		region_priority = PRIO_US_EU_JP;
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		wait_cycles(2);

		test_after_reset();
		test_rom_stream();
		test_header_region();
		test_file_index_region();
		test_quirks();
		test_cheat_code();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/cart_pkg.sv
rtl/rom_write_pacer.sv
rtl/cart_header_scan.sv
rtl/region_select.sv
rtl/cheat_code_loader.sv
rtl/cart_loader_top.sv
bench/cart_loader_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module cart_loader_tb -f sim.f -o cart_loader_sim
	./obj_dir/cart_loader_sim > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
